// ==== project.f ====
hw/subsys_pkg.sv
hw/addr_decoder.sv
hw/boot_rom.sv
hw/l2_spm.sv
hw/clint_timer.sv
hw/debug_req_gate.sv
hw/host_subsystem.sv
sim/host_subsystem_chk.sv
sim/tb_host_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the host subsystem testbench with Verilator and runs it
# Exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_host_subsystem -f project.f -o Vtb_host_subsystem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_host_subsystem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
  exit 0
fi
exit 1

// ==== sim/tb_host_subsystem.sv ====
// --------------------
// Directed testbench for the host subsystem top
// Inputs change on the falling edge and responses are read one cycle later
// The debug hold-off test must run first, right after reset release
// --------------------

module tb_host_subsystem
  import subsys_pkg::*;
();

  // Words of L2 covered by the scratchpad test
  localparam int unsigned L2Window      = 256;
  localparam int unsigned L2Writes      = 1600;
  // Rough length of all tests in cycles
  localparam int unsigned TestCycles    = DebugDelayCycles + RomWords + 2 * L2Window +
                                          L2Writes + 200;
  localparam int unsigned TimeoutCycles = 2 * TestCycles;

  logic  clk_i;
  logic  ndmreset_n;
  logic  rtc_i;
  logic  req_i;
  logic  we_i;
  addr_u addr_i;
  be_t   be_i;
  data_t wdata_i;
  logic  debug_req_i;
  logic  rvalid_o;
  data_t rdata_o;
  logic  err_o;
  logic  timer_irq_o;
  logic  ipi_o;
  logic  debug_req_o;

  integer      seed;
  int unsigned cycle_cnt;
  int unsigned data_errs;
  int unsigned flag_errs;
  int unsigned err_errs;
  int unsigned proto_errs;
  data_t       l2_model [L2Window];

  host_subsystem dut_i (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( req_i       ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .be_i        ( be_i        ),
    .wdata_i     ( wdata_i     ),
    .debug_req_i ( debug_req_i ),
    .rvalid_o    ( rvalid_o    ),
    .rdata_o     ( rdata_o     ),
    .err_o       ( err_o       ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .debug_req_o ( debug_req_o )
  );

  bind host_subsystem host_subsystem_chk chk_i (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .req_i       ( req_i       ),
    .rvalid_o    ( rvalid_o    ),
    .err_o       ( err_o       ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o ),
    .timer_irq_o ( timer_irq_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TimeoutCycles) begin
      $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("Error: %s expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
      data_errs++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error: %s expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
      flag_errs++;
    end
  endtask

  task automatic check_err(input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error: err_o expected 0x%h, got 0x%h at %0t", exp, act, $time);
      err_errs++;
    end
  endtask

  // --------------------
  // Request helpers
  // --------------------
  function automatic addr_t make_addr(input logic [15:0] page, input logic [15:0] offset);
    return {page, offset};
  endfunction

  function automatic addr_t l2_addr(input int unsigned idx);
    return make_addr(L2Page, 16'(idx * ByteCount));
  endfunction

  function automatic data_t random_word();
    return {$random(seed), $random(seed)};
  endfunction

  // One request with its response checked at the next falling edge
  task automatic access(input logic we, input addr_t addr, input be_t be, input data_t wdata,
                        input logic exp_err, input data_t exp_rdata);
    req_i      = 1'b1;
    we_i       = we;
    addr_i.raw = addr;
    be_i       = be;
    wdata_i    = wdata;
    @(negedge clk_i);
    req_i = 1'b0;
    we_i  = 1'b0;
    if (rvalid_o !== 1'b1) begin
      $display("No response one cycle after the request to address 0x%h", addr);
      proto_errs++;
    end
    check_err(exp_err, err_o);
    check_data("rdata_o", exp_rdata, rdata_o);
  endtask

  task automatic read_word(input addr_t addr, input logic exp_err, input data_t exp_rdata);
    access(1'b0, addr, '1, '0, exp_err, exp_rdata);
  endtask

  task automatic write_word(input addr_t addr, input be_t be, input data_t wdata,
                            input logic exp_err);
    access(1'b1, addr, be, wdata, exp_err, ErrRdata);
  endtask

  task automatic pulse_rtc();
    rtc_i = 1'b1;
    @(negedge clk_i);
    rtc_i = 1'b0;
    @(negedge clk_i);
  endtask

  // --------------------
  // Directed tests
  // --------------------
  task automatic test_debug_holdoff();
    check_bit("rvalid_o", 1'b0, rvalid_o);
    check_err(1'b0, err_o);
    check_bit("ipi_o", 1'b0, ipi_o);
    check_bit("timer_irq_o", 1'b0, timer_irq_o);
    for (int k = 0; k < DebugDelayCycles; k++) begin
      check_bit("debug_req_o", 1'b0, debug_req_o);
      @(negedge clk_i);
    end
    check_bit("debug_req_o", 1'b1, debug_req_o);
    debug_req_i = 1'b0;
    @(posedge clk_i);
    check_bit("debug_req_o", 1'b0, debug_req_o);
    @(negedge clk_i);
  endtask

  task automatic test_boot_rom();
    for (int i = 0; i < RomWords; i++) begin
      read_word(make_addr(RomPage, 16'(i * ByteCount)), 1'b0, rom_image[i]);
    end
    write_word(make_addr(RomPage, 16'h0000), '1, 64'h1, 1'b1);
    read_word(make_addr(RomPage, RomLength), 1'b1, ErrRdata);
  endtask

  task automatic test_l2_scratchpad();
    int unsigned idx;
    be_t         be;
    data_t       wdata;
    // Full-word fill so the model starts known
    for (int i = 0; i < L2Window; i++) begin
      wdata = random_word();
      write_word(l2_addr(i), '1, wdata, 1'b0);
      l2_model[i] = wdata;
    end
    for (int n = 0; n < L2Writes; n++) begin
      idx   = $unsigned($random(seed)) % L2Window;
      be    = be_t'($random(seed));
      wdata = random_word();
      write_word(l2_addr(idx), be, wdata, 1'b0);
      for (int b = 0; b < ByteCount; b++) begin
        if (be[b]) l2_model[idx][b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    for (int i = 0; i < L2Window; i++) begin
      read_word(l2_addr(i), 1'b0, l2_model[i]);
    end
  endtask

  task automatic test_decode_errors();
    read_word(make_addr(16'h0300, 16'h0000), 1'b1, ErrRdata);
    write_word(make_addr(16'h0300, 16'h0010), '1, '1, 1'b1);
    read_word(make_addr(L2Page, L2Length), 1'b1, ErrRdata);
    // Offset 0x8000 would land on word 0 if it were not rejected
    write_word(make_addr(L2Page, L2Length), '1, '1, 1'b1);
    read_word(l2_addr(0), 1'b0, l2_model[0]);
  endtask

  task automatic test_clint_timer();
    int unsigned pulse_counts [2];
    data_t       mtime_exp;
    pulse_counts = '{8, 10};
    write_word(make_addr(ClintPage, MsipOffset), '1, 64'h1, 1'b0);
    @(negedge clk_i);
    check_bit("ipi_o", 1'b1, ipi_o);
    read_word(make_addr(ClintPage, MsipOffset), 1'b0, 64'h1);
    write_word(make_addr(ClintPage, MsipOffset), '1, 64'h0, 1'b0);
    @(negedge clk_i);
    check_bit("ipi_o", 1'b0, ipi_o);
    // Reset values, rtc_i has not pulsed yet
    read_word(make_addr(ClintPage, MtimeOffset), 1'b0, '0);
    read_word(make_addr(ClintPage, MtimecmpOffset), 1'b0, '1);
    write_word(make_addr(ClintPage, MtimecmpOffset), '1, 64'd5, 1'b0);
    read_word(make_addr(ClintPage, MtimecmpOffset), 1'b0, 64'd5);
    foreach (pulse_counts[r]) begin
      write_word(make_addr(ClintPage, MtimeOffset), '1, '0, 1'b0);
      mtime_exp = '0;
      for (int p = 1; p <= pulse_counts[r]; p++) begin
        pulse_rtc();
        // mtime moves on every second rising edge of rtc_i
        if (p % 2 == 0) mtime_exp++;
        check_bit("timer_irq_o", mtime_exp >= 64'd5, timer_irq_o);
      end
      read_word(make_addr(ClintPage, MtimeOffset), 1'b0, data_t'(pulse_counts[r] / 2));
    end
    write_word(make_addr(ClintPage, MtimeOffset), '1, '0, 1'b0);
    @(negedge clk_i);
    check_bit("timer_irq_o", 1'b0, timer_irq_o);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    seed        = 32'h7bc67c52;
    cycle_cnt   = 0;
    data_errs   = 0;
    flag_errs   = 0;
    err_errs    = 0;
    proto_errs  = 0;
    ndmreset_n  = 1'b0;
    rtc_i       = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i.raw  = '0;
    be_i        = '0;
    wdata_i     = '0;
    debug_req_i = 1'b1;
    repeat (4) @(negedge clk_i);
    ndmreset_n = 1'b1;

    test_debug_holdoff();
    test_boot_rom();
    test_l2_scratchpad();
    test_decode_errors();
    test_clint_timer();

    $display("Errors: data %0d, flag %0d, err_o %0d, protocol %0d",
             data_errs, flag_errs, err_errs, proto_errs);
    if (data_errs + flag_errs + err_errs + proto_errs == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/host_subsystem_chk.sv ====
// --------------------
// Protocol assertions on the host subsystem top, attached with bind
// All checks are off while ndmreset_n is low
// --------------------

module host_subsystem_chk (
  input logic clk_i,
  input logic ndmreset_n,
  input logic req_i,
  input logic rvalid_o,
  input logic err_o,
  input logic debug_req_i,
  input logic debug_req_o,
  input logic timer_irq_o
);

  // One response per request, exactly one cycle later
  rvalid_follows_req: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n) rvalid_o == $past(req_i)
  ) else $error("rvalid_o does not follow req_i by one cycle");

  err_only_with_rvalid: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n) err_o |-> rvalid_o
  ) else $error("err_o raised without rvalid_o");

  // The gate can only mask, never create a request
  debug_req_masked_only: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n) debug_req_o |-> debug_req_i
  ) else $error("debug_req_o high while debug_req_i is low");

  timer_irq_known: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n) !$isunknown(timer_irq_o)
  ) else $error("timer_irq_o is unknown");

endmodule

// ==== hw/host_subsystem.sv ====
// --------------------
// Host subsystem top for a single hart
// Plain memory port, no back-pressure, one-cycle response latency
// rtc_i and debug_req_i are taken as synchronous to clk_i
// --------------------

module host_subsystem
  import subsys_pkg::*;
(
  input  logic  clk_i,
  input  logic  ndmreset_n,
  input  logic  rtc_i,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_u addr_i,
  input  be_t   be_i,
  input  data_t wdata_i,
  input  logic  debug_req_i,
  output logic  rvalid_o,
  output data_t rdata_o,
  output logic  err_o,
  output logic  timer_irq_o,
  output logic  ipi_o,
  output logic  debug_req_o
);

  logic  rom_req;
  logic  l2_req;
  logic  clint_req;
  data_t rom_rdata;
  data_t l2_rdata;
  data_t clint_rdata;

  // --------------------
  // Decode and response
  // --------------------
  addr_decoder i_addr_decoder (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .req_i         ( req_i       ),
    .we_i          ( we_i        ),
    .addr_i        ( addr_i      ),
    .rom_rdata_i   ( rom_rdata   ),
    .l2_rdata_i    ( l2_rdata    ),
    .clint_rdata_i ( clint_rdata ),
    .rom_req_o     ( rom_req     ),
    .l2_req_o      ( l2_req      ),
    .clint_req_o   ( clint_req   ),
    .rvalid_o      ( rvalid_o    ),
    .rdata_o       ( rdata_o     ),
    .err_o         ( err_o       )
  );

  // --------------------
  // Targets
  // --------------------
  boot_rom i_boot_rom (
    .clk_i    ( clk_i                ),
    .req_i    ( rom_req              ),
    .offset_i ( addr_i.fields.offset ),
    .rdata_o  ( rom_rdata            )
  );

  l2_spm i_l2_spm (
    .clk_i    ( clk_i                ),
    .req_i    ( l2_req               ),
    .we_i     ( we_i                 ),
    .offset_i ( addr_i.fields.offset ),
    .be_i     ( be_i                 ),
    .wdata_i  ( wdata_i              ),
    .rdata_o  ( l2_rdata             )
  );

  clint_timer i_clint_timer (
    .clk_i       ( clk_i                ),
    .ndmreset_n  ( ndmreset_n           ),
    .rtc_i       ( rtc_i                ),
    .req_i       ( clint_req            ),
    .we_i        ( we_i                 ),
    .offset_i    ( addr_i.fields.offset ),
    .be_i        ( be_i                 ),
    .wdata_i     ( wdata_i              ),
    .rdata_o     ( clint_rdata          ),
    .timer_irq_o ( timer_irq_o          ),
    .ipi_o       ( ipi_o                )
  );

  // Debug request hold-off
  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// ==== hw/debug_req_gate.sv ====
// --------------------
// Holds off the hart debug request after reset
// Masked for DebugDelayCycles cycles, then passed through unregistered
// --------------------

module debug_req_gate
  import subsys_pkg::*;
(
  input  logic clk_i,
  input  logic ndmreset_n,
  input  logic debug_req_i,
  output logic debug_req_o
);

  logic [DebugCntWidth-1:0] cnt_q;
  logic                     hold;

  assign hold = cnt_q != '0;

  // Down counter, parks at zero
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= DebugCntWidth'(DebugDelayCycles);
    end else if (hold) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = debug_req_i & ~hold;

endmodule

// ==== hw/clint_timer.sv ====
// --------------------
// CLINT-style timer for one hart
// rtc_i is synchronous to clk_i, mtime advances every second rising edge
// Unknown offsets read zero and drop writes
// --------------------

module clint_timer
  import subsys_pkg::*;
(
  input  logic        clk_i,
  input  logic        ndmreset_n,
  input  logic        rtc_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [15:0] offset_i,
  input  be_t         be_i,
  input  data_t       wdata_i,
  output data_t       rdata_o,
  output logic        timer_irq_o,
  output logic        ipi_o
);

  logic  rtc_q;
  logic  rtc_rise;
  logic  div_q;
  logic  tick;
  logic  sel_msip;
  logic  sel_cmp;
  logic  sel_time;
  logic  msip_q;
  logic  ipi_q;
  logic  timer_irq_q;
  data_t mtime_q;
  data_t mtimecmp_q;
  data_t rd_mux;
  data_t rdata_q;

  function automatic data_t merge_bytes(data_t old_v, data_t new_v, be_t be);
    data_t res;
    res = old_v;
    for (int b = 0; b < ByteCount; b++) begin
      if (be[b]) res[b*8 +: 8] = new_v[b*8 +: 8];
    end
    return res;
  endfunction

  // --------------------
  // RTC divider
  // --------------------
  assign rtc_rise = rtc_i & ~rtc_q;
  // Increment when the divide-by-two flag wraps
  assign tick     = rtc_rise & div_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_q <= 1'b0;
      div_q <= 1'b0;
    end else begin
      rtc_q <= rtc_i;
      if (rtc_rise) div_q <= ~div_q;
    end
  end

  // Word-aligned register select
  assign sel_msip = offset_i[15:WordLsb] == MsipOffset[15:WordLsb];
  assign sel_cmp  = offset_i[15:WordLsb] == MtimecmpOffset[15:WordLsb];
  assign sel_time = offset_i[15:WordLsb] == MtimeOffset[15:WordLsb];

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      ipi_q       <= 1'b0;
      timer_irq_q <= 1'b0;
    end else begin
      // A software write to mtime wins over a tick
      if (req_i && we_i && sel_time) begin
        mtime_q <= merge_bytes(mtime_q, wdata_i, be_i);
      end else if (tick) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (req_i && we_i && sel_cmp) begin
        mtimecmp_q <= merge_bytes(mtimecmp_q, wdata_i, be_i);
      end
      if (req_i && we_i && sel_msip && be_i[0]) begin
        msip_q <= wdata_i[0];
      end
      ipi_q       <= msip_q;
      timer_irq_q <= mtime_q >= mtimecmp_q;
    end
  end

  always_comb begin
    rd_mux = '0;
    if (sel_msip) rd_mux[0] = msip_q;
    else if (sel_cmp) rd_mux = mtimecmp_q;
    else if (sel_time) rd_mux = mtime_q;
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= rd_mux;
    end
  end

  assign rdata_o     = rdata_q;
  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = ipi_q;

endmodule

// ==== hw/l2_spm.sv ====
// --------------------
// L2 scratchpad of 4096 64-bit words
// Writes honour per-byte enables, reads return the word a cycle later
// Contents are undefined until written
// --------------------

module l2_spm
  import subsys_pkg::*;
(
  input  logic        clk_i,
  input  logic        req_i,
  input  logic        we_i,
  input  logic [15:0] offset_i,
  input  be_t         be_i,
  input  data_t       wdata_i,
  output data_t       rdata_o
);

  data_t                 mem [L2Words];
  data_t                 rdata_q;
  logic [L2IdxWidth-1:0] word_idx;

  assign word_idx = offset_i[WordLsb +: L2IdxWidth];

  // Byte lanes written independently
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < ByteCount; b++) begin
        if (be_i[b]) begin
          mem[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Registered read port
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== hw/boot_rom.sv ====
// --------------------
// Boot ROM holding the package image
// Offset is a byte offset, only the word index bits are used
// Read data holds until the next strobe
// --------------------

module boot_rom
  import subsys_pkg::*;
(
  input  logic        clk_i,
  input  logic        req_i,
  input  logic [15:0] offset_i,
  output data_t       rdata_o
);

  logic [RomIdxWidth-1:0] word_idx;
  data_t                  rdata_q;

  // Word select inside the 128-byte region
  assign word_idx = offset_i[WordLsb +: RomIdxWidth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= rom_image[word_idx];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// ==== hw/addr_decoder.sv ====
// --------------------
// Request decode and response routing for the host port
// Every request is accepted, its response follows one cycle later
// Unmapped pages, out-of-range offsets and ROM writes are errors
// --------------------

module addr_decoder
  import subsys_pkg::*;
(
  input  logic  clk_i,
  input  logic  ndmreset_n,
  input  logic  req_i,
  input  logic  we_i,
  input  addr_u addr_i,
  input  data_t rom_rdata_i,
  input  data_t l2_rdata_i,
  input  data_t clint_rdata_i,
  output logic  rom_req_o,
  output logic  l2_req_o,
  output logic  clint_req_o,
  output logic  rvalid_o,
  output data_t rdata_o,
  output logic  err_o
);

  logic rom_hit;
  logic l2_hit;
  logic clint_hit;
  logic legal;
  tgt_e tgt_d;
  tgt_e tgt_q;
  logic rvalid_q;
  logic err_q;

  // Page match plus offset within the region
  assign rom_hit   = (addr_i.fields.page == RomPage) &&
                     (addr_i.fields.offset < RomLength);
  assign l2_hit    = (addr_i.fields.page == L2Page) &&
                     (addr_i.fields.offset < L2Length);
  assign clint_hit = (addr_i.fields.page == ClintPage) &&
                     (addr_i.fields.offset < ClintLength);

  // ROM is read only
  assign rom_req_o   = req_i & rom_hit & ~we_i;
  assign l2_req_o    = req_i & l2_hit;
  assign clint_req_o = req_i & clint_hit;
  assign legal       = rom_req_o | l2_req_o | clint_req_o;

  // Writes and errors answer with ErrRdata
  always_comb begin
    tgt_d = TgtNone;
    if (legal && !we_i) begin
      if (rom_hit) tgt_d = TgtRom;
      else if (l2_hit) tgt_d = TgtL2;
      else tgt_d = TgtClint;
    end
  end

  // --------------------
  // Response stage
  // --------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      tgt_q    <= TgtNone;
    end else begin
      rvalid_q <= req_i;
      err_q    <= req_i & ~legal;
      tgt_q    <= tgt_d;
    end
  end

  always_comb begin
    unique case (tgt_q)
      TgtRom:   rdata_o = rom_rdata_i;
      TgtL2:    rdata_o = l2_rdata_i;
      TgtClint: rdata_o = clint_rdata_i;
      default:  rdata_o = ErrRdata;
    endcase
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = err_q;

endmodule

// ==== hw/subsys_pkg.sv ====
// --------------------
// Shared widths, address map and constants of the host subsystem
// One 64-bit data word per access, addresses split as page and offset
// Region bounds are checked against offsets, not full addresses
// --------------------

package subsys_pkg;

  // --------------------
  // Widths and base types
  // --------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned ByteCount = DataWidth / 8;
  // Byte address bits below the word index
  localparam int unsigned WordLsb   = $clog2(ByteCount);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [ByteCount-1:0] be_t;

  typedef struct packed {
    logic [15:0] page;
    logic [15:0] offset;
  } addr_fields_t;

  // Flat view for the master, page and offset view for decode
  typedef union packed {
    addr_t        raw;
    addr_fields_t fields;
  } addr_u;

  // --------------------
  // Address map
  // --------------------
  localparam logic [15:0] RomPage     = 16'h0001;
  localparam logic [15:0] RomLength   = 16'd128;
  localparam logic [15:0] ClintPage   = 16'h0200;
  localparam logic [15:0] ClintLength = 16'hC000;
  localparam logic [15:0] L2Page      = 16'h1C00;
  localparam logic [15:0] L2Length    = 16'h8000;

  // Response source of the previous cycle
  typedef enum logic [1:0] {
    TgtNone,
    TgtRom,
    TgtL2,
    TgtClint
  } tgt_e;

  // CLINT register offsets within its page
  localparam logic [15:0] MsipOffset     = 16'h0000;
  localparam logic [15:0] MtimecmpOffset = 16'h4000;
  localparam logic [15:0] MtimeOffset    = 16'hBFF8;

  // --------------------
  // Memories
  // --------------------
  localparam int unsigned RomWords    = 16;
  localparam int unsigned RomIdxWidth = $clog2(RomWords);
  localparam int unsigned L2Words     = int'(L2Length) / ByteCount;
  localparam int unsigned L2IdxWidth  = $clog2(L2Words);

  // Two RV64 instructions per word, lower half executes first
  localparam data_t rom_image [RomWords] = '{
    64'h00000297_f1402573, 64'h01028293_00000597,
    64'h0005b503_00058593, 64'h00050463_00000013,
    64'h10500073_000280e7, 64'hffdff06f_10500073,
    64'h00000013_00000013, 64'h00000013_00000013,
    64'h80000000_00000000, 64'h00000000_1c000000,
    64'hdeadbeef_cafef00d, 64'h0123_4567_89ab_cdef,
    64'hfedc_ba98_7654_3210, 64'h5a5a_5a5a_a5a5_a5a5,
    64'h0000_0000_0000_0001, 64'hffff_ffff_ffff_fffe
  };

  // Hold-off of the hart debug request after reset
  localparam int unsigned DebugDelayCycles = 64;
  localparam int unsigned DebugCntWidth    = $clog2(DebugDelayCycles + 1);

  // Read data of an erroring or write response
  localparam data_t ErrRdata = '0;

endpackage
